//--- include/dnc_defines.svh
/* Word widths, read-head limit, AXI register map and
   logistic pipeline depth for the free-gates subsystem */

`ifndef DNC_DEFINES_SVH
`define DNC_DEFINES_SVH

// Q4.12 sample format
`define DATA_SIZE 16
`define FRAC_BITS 12

// Read heads, one gate each
`define R_MAX    32
`define IDX_SIZE 5

// AXI4-Lite bus widths
`define AXI_ADDR_SIZE 12
`define AXI_DATA_SIZE 32

// Register map, byte addresses
`define CTRL_ADDR   12'h000
`define STATUS_ADDR 12'h004
`define LOGIT_BASE  12'h100
`define GATE_BASE   12'h200

// Cycles from logit in to gate out
`define LOGISTIC_LATENCY 2

`endif

//--- logic/dnc_types_pkg.sv
/* Fixed-point logit and gate types, element index
   and status word layout */

`include "dnc_defines.svh"

package dnc_types_pkg;

  // Signed Q4.12, range -8.0 up to just below 8.0
  typedef logic signed [`DATA_SIZE-1:0] logit_t;

  // Unsigned Q4.12, only [0, 1] is ever produced
  typedef logic [`DATA_SIZE-1:0] gate_t;

  // Element index, 0 .. R-1
  typedef logic [`IDX_SIZE-1:0] gate_idx_t;

  // 1.0 in gate format
  localparam gate_t GATE_ONE = gate_t'(1 << `FRAC_BITS);

  // Status word, bit 1 done and bit 0 busy
  typedef struct packed {
    logic done;
    logic busy;
  } status_t;

endpackage

//--- logic/axi_lite_pkg.sv
/* AXI4-Lite response codes, register regions,
   write-data union and address decode */

`include "dnc_defines.svh"

package axi_lite_pkg;

  typedef enum logic [1:0] {
    AXI_OKAY   = 2'b00,
    AXI_SLVERR = 2'b10
  } axi_resp_t;

  typedef enum logic [2:0] {
    REGION_CTRL,
    REGION_STATUS,
    REGION_LOGIT,
    REGION_GATE,
    REGION_NONE
  } axi_region_t;

  // One write word, read as control or as a logit sample
  typedef union packed {
    struct packed {
      logic                                 start;
      logic [`AXI_DATA_SIZE-`IDX_SIZE-3:0] reserved;
      logic [`IDX_SIZE:0]                   size;
    } ctrl;
    struct packed {
      logic [`AXI_DATA_SIZE-`DATA_SIZE-1:0] reserved;
      logic [`DATA_SIZE-1:0]                logit;
    } sample;
  } axi_wdata_u;

  //////////////////////////////////////////////////
  // Address decode
  //////////////////////////////////////////////////

  function automatic axi_region_t decode_region(input logic [`AXI_ADDR_SIZE-1:0] addr);
    logic [`AXI_ADDR_SIZE-1:0] base;
    // Strip the word index inside a 32-entry array
    base = addr & ~`AXI_ADDR_SIZE'((`R_MAX << 2) - 1);
    // Only whole words are mapped
    if (addr[1:0] != 2'b00) return REGION_NONE;
    if (addr == `CTRL_ADDR) return REGION_CTRL;
    if (addr == `STATUS_ADDR) return REGION_STATUS;
    if (base == `LOGIT_BASE) return REGION_LOGIT;
    if (base == `GATE_BASE) return REGION_GATE;
    return REGION_NONE;
  endfunction

endpackage

//--- logic/gate_stream_if.sv
/* Element stream, one logit or gate per cycle */

`include "dnc_defines.svh"

interface gate_stream_if import dnc_types_pkg::*; ();

  // No ready, every cycle with valid high is a transfer
  logic                  valid;
  gate_idx_t             idx;
  // Marks element R-1
  logic                  last;
  // Logit on the input side, gate on the output side
  logic [`DATA_SIZE-1:0] data;

  modport source (
    output valid, idx, last, data
  );

  modport sink (
    input valid, idx, last, data
  );

endinterface

//--- logic/dnc_gate_loader.sv
/* Input side: AXI4-Lite write channel, logit memory,
   size register and element streaming after start */

`include "dnc_defines.svh"

module dnc_gate_loader import dnc_types_pkg::*, axi_lite_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  input  logic [`AXI_ADDR_SIZE-1:0] awaddr,
  input  logic                      awvalid,
  input  logic [`AXI_DATA_SIZE-1:0] wdata,
  input  logic                      wvalid,
  input  logic                      bready,
  output logic                      awready,
  output logic                      wready,
  output logic                      bvalid,
  output axi_resp_t                 bresp,
  input  logic                      busy,
  output logic                      streaming,
  gate_stream_if.source             logit_stream
);

  logit_t             logit_mem [`R_MAX];
  logic [`IDX_SIZE:0] size_q;
  gate_idx_t          idx_q;
  logic               accept_q;
  logic               wr_fire;
  axi_region_t        wr_region;
  axi_wdata_u         wr_word;
  logic               size_ok;
  logic               wr_ok;

  //////////////////////////////////////////////////
  // Write decode
  //////////////////////////////////////////////////

  // AW and W taken together, one cycle of ready
  assign awready = accept_q;
  assign wready  = accept_q;
  assign wr_fire = accept_q && awvalid && wvalid;

  assign wr_region = decode_region(awaddr);
  assign wr_word   = wdata;

  // R must be 1 .. R_MAX
  assign size_ok = (wr_word.ctrl.size != '0) && (wr_word.ctrl.size <= `R_MAX);

  always_comb begin
    case (wr_region)
      // Control without start is a harmless no-op
      REGION_CTRL:  wr_ok = !busy && (!wr_word.ctrl.start || size_ok);
      REGION_LOGIT: wr_ok = !busy;
      // Status, gates and holes are read-only or unmapped
      default:      wr_ok = 1'b0;
    endcase
  end

  //////////////////////////////////////////////////
  // Handshake, storage and streaming
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      accept_q  <= 1'b0;
      bvalid    <= 1'b0;
      bresp     <= AXI_OKAY;
      size_q    <= '0;
      idx_q     <= '0;
      streaming <= 1'b0;
      for (int i = 0; i < `R_MAX; i++) begin
        logit_mem[i] <= '0;
      end
    end else begin
      // No new request while a B response is pending
      accept_q <= awvalid && wvalid && !accept_q && !bvalid;

      if (wr_fire) begin
        bvalid <= 1'b1;
        if (wr_ok) begin
          bresp <= AXI_OKAY;
        end else begin
          bresp <= AXI_SLVERR;
        end
      end else if (bvalid && bready) begin
        bvalid <= 1'b0;
      end

      // Walk the stored logits, one per cycle
      if (streaming) begin
        if (logit_stream.last) begin
          streaming <= 1'b0;
        end else begin
          idx_q <= idx_q + 1'b1;
        end
      end

      // wr_ok implies not busy, so never overlaps streaming
      if (wr_fire && wr_ok) begin
        if (wr_region == REGION_LOGIT) begin
          logit_mem[awaddr[`IDX_SIZE+1:2]] <= logit_t'(wr_word.sample.logit);
        end else if (wr_word.ctrl.start) begin
          size_q    <= wr_word.ctrl.size;
          idx_q     <= '0;
          streaming <= 1'b1;
        end
      end
    end
  end

  assign logit_stream.valid = streaming;
  assign logit_stream.idx   = idx_q;
  assign logit_stream.last  = ({1'b0, idx_q} == size_q - 1'b1);
  assign logit_stream.data  = logit_mem[idx_q];

  // Never streams past the requested R
  a_idx_in_range: assert property (
    @(posedge clk) disable iff (reset)
    logit_stream.valid |-> ({1'b0, logit_stream.idx} < size_q)
  );

endmodule

//--- logic/ntm_logistic_function.sv
/* Two-stage piecewise-linear sigmoid on one Q4.12 sample */

`include "dnc_defines.svh"

module ntm_logistic_function import dnc_types_pkg::*; (
  input  logic   clk,
  input  logic   reset,
  input  logic   in_valid,
  input  logit_t in_data,
  output logic   out_valid,
  output gate_t  out_data
);

  // Segment codes, ordered by |x|
  localparam logic [1:0] SEG_LOW  = 2'd0;
  localparam logic [1:0] SEG_MID  = 2'd1;
  localparam logic [1:0] SEG_HIGH = 2'd2;
  localparam logic [1:0] SEG_SAT  = 2'd3;

  // Breakpoints 2.375 and 5.0
  localparam gate_t X_MID_END = gate_t'(19 << (`FRAC_BITS - 3));
  localparam gate_t X_SAT     = gate_t'(5 << `FRAC_BITS);

  // Offsets 0.5, 0.625 and 0.84375
  localparam gate_t OFS_LOW  = gate_t'(1 << (`FRAC_BITS - 1));
  localparam gate_t OFS_MID  = gate_t'(5 << (`FRAC_BITS - 3));
  localparam gate_t OFS_HIGH = gate_t'(27 << (`FRAC_BITS - 5));

  gate_t      abs_x;
  logic [1:0] seg;
  logic       s1_valid;
  gate_t      s1_abs;
  logic       s1_neg;
  logic [1:0] s1_seg;
  gate_t      y_pos;

  //////////////////////////////////////////////////
  // Stage one, magnitude and segment
  //////////////////////////////////////////////////

  // -8.0 maps to 0x8000, still right as unsigned
  assign abs_x = in_data[`DATA_SIZE-1] ? gate_t'(-in_data) : gate_t'(in_data);

  always_comb begin
    if (abs_x >= X_SAT) seg = SEG_SAT;
    else if (abs_x >= X_MID_END) seg = SEG_HIGH;
    else if (abs_x >= GATE_ONE) seg = SEG_MID;
    else seg = SEG_LOW;
  end

  //////////////////////////////////////////////////
  // Stage two, slope, offset and mirror
  //////////////////////////////////////////////////

  // Shifts truncate toward zero on the magnitude
  always_comb begin
    case (s1_seg)
      SEG_LOW:  y_pos = (s1_abs >> 2) + OFS_LOW;
      SEG_MID:  y_pos = (s1_abs >> 3) + OFS_MID;
      SEG_HIGH: y_pos = (s1_abs >> 5) + OFS_HIGH;
      default:  y_pos = GATE_ONE;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      s1_valid  <= 1'b0;
      out_valid <= 1'b0;
    end else begin
      s1_valid  <= in_valid;
      out_valid <= s1_valid;
    end
  end

  // Data path
  always_ff @(posedge clk) begin
    s1_abs <= abs_x;
    s1_neg <= in_data[`DATA_SIZE-1];
    s1_seg <= seg;
    // sigmoid(-x) = 1 - sigmoid(x)
    out_data <= s1_neg ? GATE_ONE - y_pos : y_pos;
  end

  a_gate_bounded: assert property (
    @(posedge clk) disable iff (reset)
    out_valid |-> (out_data <= GATE_ONE)
  );

endmodule

//--- logic/dnc_free_gates.sv
/* Free-gate processing: logistic unit with idx/last
   sideband and in-flight tracking */

`include "dnc_defines.svh"

module dnc_free_gates import dnc_types_pkg::*; (
  input  logic          clk,
  input  logic          reset,
  gate_stream_if.sink   logit_in,
  gate_stream_if.source gate_out,
  output logic          busy
);

  // Sideband delay line, matched to the logistic unit
  gate_idx_t idx_pipe  [`LOGISTIC_LATENCY];
  logic      last_pipe [`LOGISTIC_LATENCY];

  logic [$clog2(`LOGISTIC_LATENCY+1)-1:0] inflight;

  gate_t gate_value;
  logic  gate_valid;

  // f(i) = sigmoid(logit(i))
  ntm_logistic_function logistic_function (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (logit_in.valid),
    .in_data   (logit_t'(logit_in.data)),
    .out_valid (gate_valid),
    .out_data  (gate_value)
  );

  always_ff @(posedge clk) begin
    idx_pipe[0]  <= logit_in.idx;
    last_pipe[0] <= logit_in.last;
    for (int i = 1; i < `LOGISTIC_LATENCY; i++) begin
      idx_pipe[i]  <= idx_pipe[i-1];
      last_pipe[i] <= last_pipe[i-1];
    end
  end

  // Elements entered minus elements left
  always_ff @(posedge clk) begin
    if (reset) begin
      inflight <= '0;
    end else begin
      case ({logit_in.valid, gate_valid})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: inflight <= inflight;
      endcase
    end
  end

  // High from the first input until the last result leaves
  assign busy = logit_in.valid || (inflight != '0);

  assign gate_out.valid = gate_valid;
  assign gate_out.idx   = idx_pipe[`LOGISTIC_LATENCY-1];
  assign gate_out.last  = last_pipe[`LOGISTIC_LATENCY-1];
  assign gate_out.data  = gate_value;

  a_inflight_max: assert property (
    @(posedge clk) disable iff (reset)
    inflight <= `LOGISTIC_LATENCY
  );

endmodule

//--- logic/dnc_gate_collector.sv
/* Output side: gate result memory, done flag and
   AXI4-Lite read channel for status and gates */

`include "dnc_defines.svh"

module dnc_gate_collector import dnc_types_pkg::*, axi_lite_pkg::*; (
  input  logic                      clk,
  input  logic                      reset,
  gate_stream_if.sink               gate_in,
  input  logic                      start_seen,
  input  logic                      busy,
  input  logic [`AXI_ADDR_SIZE-1:0] araddr,
  input  logic                      arvalid,
  input  logic                      rready,
  output logic                      arready,
  output logic                      rvalid,
  output logic [`AXI_DATA_SIZE-1:0] rdata,
  output axi_resp_t                 rresp
);

  gate_t                     gate_mem [`R_MAX];
  logic                      done;
  status_t                   status;
  logic                      ar_accept_q;
  logic                      rd_fire;
  axi_region_t               rd_region;
  logic [`AXI_DATA_SIZE-1:0] rd_data;
  axi_resp_t                 rd_resp;

  //////////////////////////////////////////////////
  // Result capture
  //////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      done <= 1'b0;
      for (int i = 0; i < `R_MAX; i++) begin
        gate_mem[i] <= '0;
      end
    end else begin
      if (start_seen) begin
        done <= 1'b0;
      end
      if (gate_in.valid) begin
        gate_mem[gate_in.idx] <= gate_in.data;
        // Done in the same cycle as the last gate
        if (gate_in.last) begin
          done <= 1'b1;
        end
      end
    end
  end

  assign status = '{done: done, busy: busy};

  //////////////////////////////////////////////////
  // Read channel
  //////////////////////////////////////////////////

  assign arready   = ar_accept_q;
  assign rd_fire   = ar_accept_q && arvalid;
  assign rd_region = decode_region(araddr);

  // Logits and control are write-only
  always_comb begin
    rd_data = '0;
    rd_resp = AXI_OKAY;
    case (rd_region)
      REGION_STATUS: rd_data = `AXI_DATA_SIZE'(status);
      REGION_GATE:   rd_data = `AXI_DATA_SIZE'(gate_mem[araddr[`IDX_SIZE+1:2]]);
      default:       rd_resp = AXI_SLVERR;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ar_accept_q <= 1'b0;
      rvalid      <= 1'b0;
      rresp       <= AXI_OKAY;
    end else begin
      // Hold off AR while an R beat is waiting
      ar_accept_q <= arvalid && !ar_accept_q && !rvalid;
      if (rd_fire) begin
        rvalid <= 1'b1;
        rresp  <= rd_resp;
      end else if (rvalid && rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  // Captured once per request
  always_ff @(posedge clk) begin
    if (rd_fire) begin
      rdata <= rd_data;
    end
  end

  a_rdata_hold: assert property (
    @(posedge clk) disable iff (reset)
    (rvalid && !rready) |=> (rvalid && $stable(rdata))
  );

endmodule

//--- logic/dnc_free_gates_top.sv
/* Free-gates subsystem top: AXI4-Lite slave ports,
   loader, logistic processing and collector */

`include "dnc_defines.svh"

module dnc_free_gates_top (
  input  logic                      clk,
  input  logic                      reset,
  // Write address and data
  input  logic [`AXI_ADDR_SIZE-1:0] awaddr,
  input  logic                      awvalid,
  output logic                      awready,
  input  logic [`AXI_DATA_SIZE-1:0] wdata,
  input  logic                      wvalid,
  output logic                      wready,
  // Write response
  output logic                      bvalid,
  input  logic                      bready,
  output logic [1:0]                bresp,
  // Read address and data
  input  logic [`AXI_ADDR_SIZE-1:0] araddr,
  input  logic                      arvalid,
  output logic                      arready,
  output logic                      rvalid,
  input  logic                      rready,
  output logic [`AXI_DATA_SIZE-1:0] rdata,
  output logic [1:0]                rresp
);

  gate_stream_if logit_stream ();
  gate_stream_if gate_stream ();

  logic streaming;
  logic free_gates_busy;
  logic busy;
  logic start_seen;

  // Loader streaming or elements still in the logistic unit
  assign busy = streaming || free_gates_busy;

  // Element 0 leaving the loader marks a new run
  assign start_seen = logit_stream.valid && (logit_stream.idx == '0);

  dnc_gate_loader gate_loader (
    .clk, .reset,
    .awaddr, .awvalid, .awready,
    .wdata, .wvalid, .wready,
    .bvalid, .bready, .bresp,
    .busy, .streaming,
    .logit_stream (logit_stream)
  );

  dnc_free_gates free_gates (
    .clk, .reset,
    .logit_in (logit_stream),
    .gate_out (gate_stream),
    .busy     (free_gates_busy)
  );

  dnc_gate_collector gate_collector (
    .clk, .reset,
    .gate_in (gate_stream),
    .start_seen, .busy,
    .araddr, .arvalid, .arready,
    .rvalid, .rready, .rdata, .rresp
  );

endmodule

//--- verification/dnc_free_gates_checker.sv
/* Response checker: queues of expected B and R responses,
   hold checks under back-pressure and error counting */

module dnc_free_gates_checker (
  input  logic         clk,
  input  logic         reset,
  input  logic         bvalid,
  input  logic         bready,
  input  logic [1:0]   bresp,
  input  logic         rvalid,
  input  logic         rready,
  input  logic [31:0]  rdata,
  input  logic [1:0]   rresp,
  input  logic         exp_push,
  input  logic         exp_read,
  input  logic [1:0]   exp_resp,
  input  logic [31:0]  exp_data,
  input  logic [31:0]  exp_mask,
  input  logic [159:0] exp_name,
  output int           errors,
  output int           checks
);

  timeunit 1ns;
  timeprecision 100ps;

  // Expectations in request order, one queue per path
  logic [1:0]   wq_resp [$];
  logic [159:0] wq_name [$];
  logic [1:0]   rq_resp [$];
  logic [31:0]  rq_data [$];
  logic [31:0]  rq_mask [$];
  logic [159:0] rq_name [$];

  // Response state seen at the previous edge
  logic         b_wait;
  logic [1:0]   bresp_q;
  logic         r_wait;
  logic [1:0]   rresp_q;
  logic [31:0]  rdata_q;

  initial begin
    errors = 0;
    checks = 0;
  end

  always @(posedge clk) begin
    logic [159:0] name;
    logic [1:0]   resp;
    logic [31:0]  data;
    logic [31:0]  mask;
    if (reset) begin
      wq_resp.delete();
      wq_name.delete();
      rq_resp.delete();
      rq_data.delete();
      rq_mask.delete();
      rq_name.delete();
      b_wait = 1'b0;
      r_wait = 1'b0;
    end else begin
      if (exp_push) begin
        if (exp_read) begin
          rq_resp.push_back(exp_resp);
          rq_data.push_back(exp_data);
          rq_mask.push_back(exp_mask);
          rq_name.push_back(exp_name);
        end else begin
          wq_resp.push_back(exp_resp);
          wq_name.push_back(exp_name);
        end
      end

      ////////////////////////////////////////////////
      // Held responses must not move
      ////////////////////////////////////////////////
      if (b_wait && (!bvalid || bresp != bresp_q)) begin
        errors++;
        $display("B response dropped or changed while bready was low (%0s)", exp_name);
      end
      if (r_wait && (!rvalid || rresp != rresp_q || rdata != rdata_q)) begin
        errors++;
        $display("R response dropped or changed while rready was low (%0s)", exp_name);
      end

      // Write response handshake
      if (bvalid && bready) begin
        checks++;
        if (wq_resp.size() == 0) begin
          errors++;
          $display("write response arrived with no write outstanding");
        end else begin
          name = wq_name.pop_front();
          resp = wq_resp.pop_front();
          if (bresp !== resp) begin
            errors++;
            $display("CHECK FAILED %0s bresp expected %0d actual %0d", name, resp, bresp);
          end
        end
      end

      // Read response handshake, data compared under the mask
      if (rvalid && rready) begin
        checks++;
        if (rq_resp.size() == 0) begin
          errors++;
          $display("read response arrived with no read outstanding");
        end else begin
          name = rq_name.pop_front();
          resp = rq_resp.pop_front();
          data = rq_data.pop_front();
          mask = rq_mask.pop_front();
          if (rresp !== resp) begin
            errors++;
            $display("CHECK FAILED %0s rresp expected %0d actual %0d", name, resp, rresp);
          end else if ((rdata & mask) !== (data & mask)) begin
            errors++;
            $display("CHECK FAILED %0s rdata expected %h actual %h", name, data & mask,
                     rdata & mask);
          end
        end
      end

      b_wait  = bvalid && !bready;
      bresp_q = bresp;
      r_wait  = rvalid && !rready;
      rresp_q = rresp;
      rdata_q = rdata;
    end
  end

endmodule

//--- verification/tb_dnc_free_gates.sv
/* Testbench top: clock, reset, LFSR, case file, AXI4-Lite
   master tasks, test sequence and timeout */

`include "dnc_defines.svh"

module tb_dnc_free_gates;

  timeunit 1ns;
  timeprecision 100ps;

  logic        clk;
  logic        reset;
  logic [11:0] awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic        wvalid;
  logic        wready;
  logic        bvalid;
  logic        bready;
  logic [1:0]  bresp;
  logic [11:0] araddr;
  logic        arvalid;
  logic        arready;
  logic        rvalid;
  logic        rready;
  logic [31:0] rdata;
  logic [1:0]  rresp;

  // Expectation channel to the checker
  logic         exp_push;
  logic         exp_read;
  logic [1:0]   exp_resp;
  logic [31:0]  exp_data;
  logic [31:0]  exp_mask;
  logic [159:0] test_name;
  int           chk_errors;
  int           chk_checks;

  // Case file contents
  logic [15:0] case_logit [32];
  logic [15:0] case_gate [32];
  logic [11:0] err_addr [32];
  logic [31:0] err_data [32];
  logic [1:0]  err_resp [32];
  bit          err_is_read [32];
  int          n_gate;
  int          n_err;

  // Model of stored logits and gates
  logic [15:0] logit_model [32];
  logic [15:0] gate_model [32];

  logic [31:0] lfsr;
  int          cycles;
  int          timeout_limit;
  int          tests;
  int          failed;
  int          tb_errors;
  int          err_start;

  dnc_free_gates_top dut (
    .clk, .reset,
    .awaddr, .awvalid, .awready, .wdata, .wvalid, .wready,
    .bvalid, .bready, .bresp,
    .araddr, .arvalid, .arready, .rvalid, .rready, .rdata, .rresp
  );

  dnc_free_gates_checker response_checker (
    .clk, .reset, .bvalid, .bready, .bresp, .rvalid, .rready, .rdata, .rresp,
    .exp_push, .exp_read, .exp_resp, .exp_data, .exp_mask,
    .exp_name (test_name),
    .errors   (chk_errors),
    .checks   (chk_checks)
  );

  initial clk = 1'b0;
  always #5 clk = ~clk;

  // Run limit from the number of planned accesses
  always @(posedge clk) begin
    cycles++;
    if (timeout_limit > 0 && cycles > timeout_limit) begin
      $display("timeout after %0d cycles, run did not finish", cycles);
      $display("** FAIL **");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  function automatic logic [31:0] random_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v = {v[30:0], lfsr[0]};
    end
    return v;
  endfunction

  // Piecewise-linear logistic, Q4.12 in and out
  function automatic logic [15:0] sigmoid_ref(input logic [15:0] x);
    int ax;
    int y;
    ax = x[15] ? 65536 - int'(x) : int'(x);
    if (ax >= 20480) y = 4096;
    else if (ax >= 9728) y = ax / 32 + 3456;
    else if (ax >= 4096) y = ax / 8 + 2560;
    else y = ax / 4 + 2048;
    if (x[15]) y = 4096 - y;
    return 16'(y);
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic push_expect(input logic is_read, input logic [1:0] resp,
                             input logic [31:0] data, input logic [31:0] mask);
    exp_read = is_read;
    exp_resp = resp;
    exp_data = data;
    exp_mask = mask;
    exp_push = 1'b1;
    next_cycle();
    exp_push = 1'b0;
  endtask

  task automatic write_reg(input logic [11:0] addr, input logic [31:0] data,
                           input logic [1:0] resp, input int hold);
    push_expect(1'b0, resp, '0, '0);
    awaddr  = addr;
    wdata   = data;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    @(negedge clk);
    while (!(awready && wready)) @(negedge clk);
    next_cycle();
    awvalid = 1'b0;
    wvalid  = 1'b0;
    while (!bvalid) @(negedge clk);
    next_cycle();
    repeat (hold) next_cycle();
    bready = 1'b1;
    next_cycle();
    bready = 1'b0;
  endtask

  task automatic read_reg(input logic [11:0] addr, input logic [1:0] resp,
                          input logic [31:0] data, input logic [31:0] mask,
                          input int hold, output logic [31:0] value);
    push_expect(1'b1, resp, data, mask);
    araddr  = addr;
    arvalid = 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    next_cycle();
    arvalid = 1'b0;
    while (!rvalid) @(negedge clk);
    value = rdata;
    next_cycle();
    repeat (hold) next_cycle();
    rready = 1'b1;
    next_cycle();
    rready = 1'b0;
  endtask

  // Poll status until done
  task automatic wait_done();
    logic [31:0] st;
    st = '0;
    while (!st[1]) read_reg(`STATUS_ADDR, 2'd0, '0, '0, 0, st);
  endtask

  task automatic start_run(input int r, input logic [1:0] resp);
    write_reg(`CTRL_ADDR, 32'h8000_0000 | 32'(r), resp, 0);
  endtask

  task automatic end_test();
    tests++;
    if (chk_errors != err_start) begin
      failed++;
      $display("test %0s: FAILED, %0d errors", test_name, chk_errors - err_start);
    end else begin
      $display("test %0s: ok", test_name);
    end
  endtask

  task automatic read_cases();
    int          fd;
    int          code;
    string       tok;
    string       rest;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] c;
    fd = $fopen("verification/free_gates_cases.txt", "r");
    if (fd == 0) begin
      tb_errors++;
      $display("could not open the case file");
      return;
    end
    while (!$feof(fd)) begin
      code = $fscanf(fd, "%s", tok);
      if (code != 1) break;
      if (tok == "#") begin
        code = $fgets(rest, fd);
      end else if (tok == "L") begin
        code = $fscanf(fd, "%h %h", a, b);
        case_logit[n_gate] = a[15:0];
        case_gate[n_gate]  = b[15:0];
        n_gate++;
      end else if (tok == "W") begin
        code = $fscanf(fd, "%h %h %d", a, b, c);
        err_is_read[n_err] = 1'b0;
        err_addr[n_err]    = a[11:0];
        err_data[n_err]    = b;
        err_resp[n_err]    = c[1:0];
        n_err++;
      end else begin
        code = $fscanf(fd, "%h %d", a, c);
        err_is_read[n_err] = 1'b1;
        err_addr[n_err]    = a[11:0];
        err_resp[n_err]    = c[1:0];
        n_err++;
      end
    end
    $fclose(fd);
  endtask

  //////////////////////////////////////////////////
  // Test sequence
  //////////////////////////////////////////////////

  initial begin
    logic [31:0] v;
    int          r;
    int          hold;
    awaddr = '0;
    awvalid = 1'b0;
    wdata = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    exp_push = 1'b0;
    exp_read = 1'b0;
    exp_resp = '0;
    exp_data = '0;
    exp_mask = '0;
    test_name = "reset";
    lfsr = 32'he797;
    cycles = 0;
    timeout_limit = 0;
    tests = 0;
    failed = 0;
    tb_errors = 0;
    n_gate = 0;
    n_err = 0;
    for (int i = 0; i < 32; i++) begin
      logit_model[i] = '0;
      gate_model[i]  = '0;
    end
    reset = 1'b1;
    repeat (16) @(posedge clk);
    #1;
    reset = 1'b0;
    read_cases();
    timeout_limit = 200 * (2 * n_gate + n_err + 110);

    // Case-file logits across all segments
    test_name = "case_gates";
    err_start = chk_errors;
    for (int i = 0; i < n_gate; i++) begin
      write_reg(`LOGIT_BASE + 12'(4 * i), 32'(case_logit[i]), 2'd0, 0);
      logit_model[i] = case_logit[i];
    end
    start_run(n_gate, 2'd0);
    wait_done();
    for (int i = 0; i < n_gate; i++) begin
      read_reg(`GATE_BASE + 12'(4 * i), 2'd0, 32'(case_gate[i]), '1, 0, v);
      gate_model[i] = case_gate[i];
    end
    end_test();

    // Status and rejected writes while busy
    test_name = "busy_status";
    err_start = chk_errors;
    start_run(32, 2'd0);
    read_reg(`STATUS_ADDR, 2'd0, 32'h1, '1, 0, v);
    write_reg(`LOGIT_BASE, 32'h0000_1234, 2'd2, 0);
    start_run(4, 2'd2);
    wait_done();
    for (int i = 0; i < 32; i++) gate_model[i] = sigmoid_ref(logit_model[i]);
    read_reg(`STATUS_ADDR, 2'd0, 32'h2, '1, 0, v);
    read_reg(`GATE_BASE, 2'd0, 32'(gate_model[0]), '1, 0, v);
    read_reg(`GATE_BASE + 12'h7c, 2'd0, 32'(gate_model[31]), '1, 0, v);
    end_test();

    // Error accesses from the case file
    test_name = "access_errors";
    err_start = chk_errors;
    for (int i = 0; i < n_err; i++) begin
      if (err_is_read[i]) read_reg(err_addr[i], err_resp[i], '0, '1, 0, v);
      else write_reg(err_addr[i], err_data[i], err_resp[i], 0);
    end
    end_test();

    // Random logits, random R, upper gates untouched
    test_name = "random_gates";
    err_start = chk_errors;
    for (int i = 0; i < 20; i++) begin
      logit_model[i] = 16'(random_bits(16));
      write_reg(`LOGIT_BASE + 12'(4 * i), 32'(logit_model[i]), 2'd0, 0);
    end
    r = 1 + int'(random_bits(5)) % 20;
    start_run(r, 2'd0);
    wait_done();
    for (int i = 0; i < r; i++) gate_model[i] = sigmoid_ref(logit_model[i]);
    for (int i = 0; i < 32; i++) begin
      read_reg(`GATE_BASE + 12'(4 * i), 2'd0, 32'(gate_model[i]), '1, 0, v);
    end
    end_test();

    // Held responses under back-pressure
    test_name = "backpressure";
    err_start = chk_errors;
    for (int i = 0; i < 8; i++) begin
      hold = int'(random_bits(3));
      read_reg(`GATE_BASE + 12'(4 * i), 2'd0, 32'(gate_model[i]), '1, hold, v);
      hold = int'(random_bits(3));
      logit_model[i] = 16'(random_bits(16));
      write_reg(`LOGIT_BASE + 12'(4 * i), 32'(logit_model[i]), 2'd0, hold);
    end
    read_reg(`STATUS_ADDR, 2'd0, 32'h2, '1, int'(random_bits(3)), v);
    end_test();

    repeat (4) next_cycle();
    $display("tests %0d, failed %0d, checks %0d, errors %0d", tests, failed, chk_checks,
             chk_errors + tb_errors);
    if (failed == 0 && chk_errors == 0 && tb_errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

//--- verification/free_gates_cases.txt
# L <logit hex> <gate hex> : one logit and its expected gate, stored at the next free index
# W <addr hex> <wdata hex> <bresp> : write access ; R <addr hex> <rresp> : read access
L 0000 0800
L 0400 0900
L fc00 0700
L 0fff 0bff
L 1000 0c00
L f000 0400
L 25ff 0ebf
L 2600 0eb0
L da00 0150
L 4fff 0fff
L 5000 1000
L b000 0000
L 7fff 1000
L 8000 0000
L c000 0080
L 1800 0d00
L e800 0300
L ffff 0800
L 0001 0800
L f001 0401
W 008 00000000 2
W 004 00000000 2
W 200 00000000 2
W 102 00000000 2
W 180 00000000 2
W 000 80000000 2
W 000 80000021 2
W 000 00000005 0
R 000 2
R 100 2
R 300 2
R 006 2

//--- filelist.f
+incdir+include
logic/dnc_types_pkg.sv
logic/axi_lite_pkg.sv
logic/gate_stream_if.sv
logic/dnc_gate_loader.sv
logic/ntm_logistic_function.sv
logic/dnc_free_gates.sv
logic/dnc_gate_collector.sv
logic/dnc_free_gates_top.sv
verification/dnc_free_gates_checker.sv
verification/tb_dnc_free_gates.sv

//--- Makefile
TOP = tb_dnc_free_gates

.PHONY: compile run clean

compile:
	verilator --binary --timing --assert -f filelist.f --top-module $(TOP) -Mdir obj_dir

run: compile
	./obj_dir/V$(TOP) | tee sim.log
	grep -q "^\*\* PASS \*\*$$" sim.log

clean:
	rm -rf obj_dir sim.log
